/* hw/ctrlPkg.sv */
package ctrlPkg;

  //////////////////////////////////////////////////////////////////////
  // Encodings

  localparam int instrW = 32;                  // Instruction width

  localparam logic [6:0] opLoad    = 7'b0000011; // Loads
  localparam logic [6:0] opMiscMem = 7'b0001111; // fence and fence.i
  localparam logic [6:0] opOpImm   = 7'b0010011; // I-type ALU
  localparam logic [6:0] opAuipc   = 7'b0010111;
  localparam logic [6:0] opStore   = 7'b0100011; // Stores
  localparam logic [6:0] opOp      = 7'b0110011; // R-type and M extension
  localparam logic [6:0] opLui     = 7'b0110111;
  localparam logic [6:0] opBranch  = 7'b1100011;
  localparam logic [6:0] opJalr    = 7'b1100111;
  localparam logic [6:0] opJal     = 7'b1101111;
  localparam logic [6:0] opSystem  = 7'b1110011; // Privileged and CSR

  localparam logic [2:0] immI = 3'b000;        // Immediate formats
  localparam logic [2:0] immS = 3'b001;
  localparam logic [2:0] immB = 3'b010;
  localparam logic [2:0] immJ = 3'b011;
  localparam logic [2:0] immU = 3'b100;

  localparam logic [2:0] resAlu = 3'b000;      // Writeback result sources
  localparam logic [2:0] resMem = 3'b001;
  localparam logic [2:0] resCsr = 3'b010;
  localparam logic [2:0] resMdu = 3'b011;

  localparam logic [6:0] f7Zero   = 7'b0000000; // Base R-type and shifts
  localparam logic [6:0] f7Alt    = 7'b0100000; // sub and sra
  localparam logic [6:0] f7MulDiv = 7'b0000001; // M extension

  //////////////////////////////////////////////////////////////////////
  // Control words

  typedef struct packed {
    logic       regWrite;
    logic [2:0] immSrc;
    logic       aluSrcA, aluSrcB;              // ALU operand selects
    logic [1:0] memRw;                         // Bit 1 read, bit 0 write
    logic [2:0] resultSrc;
    logic       branch, aluOp, jump;
    logic       aluResultSrc;
    logic       csrRead, privileged;
    logic       fenceX;                        // Any legal fence encoding
    logic       mdu, illegal;
  } ctrlWordT;

  typedef struct packed {
    logic [2:0] aluSelect;
    logic       regWrite;
    logic [2:0] resultSrc;
    logic [1:0] memRw;
    logic       jump, branch;
    logic       aluSrcA, aluSrcB, aluResultSrc;
    logic       csrRead, csrWrite, privileged;
    logic [2:0] funct3;
    logic       subArith, mdu;
    logic       invalidateICache, flushDCache, fence;
    logic       instrValid;
  } execCtrlT;

  typedef struct packed {
    logic       regWrite;
    logic [2:0] resultSrc;
    logic [1:0] memRw;
    logic       csrRead, csrWrite, privileged;
    logic [2:0] funct3;
    logic       invalidateICache, flushDCache, fence;
    logic       instrValid, intDiv;
  } memCtrlT;

  typedef struct packed {
    logic       regWrite;
    logic [2:0] resultSrc;
    logic       intDiv;
  } wbCtrlT;

endpackage

/* hw/decodeIf.sv */
`timescale 1ns/10ps

interface decodeIf (
  input logic clk                              // Sampling clock for decoder checks
);
  logic [ctrlPkg::instrW-1:0] instr;           // Decode-stage instruction
  ctrlPkg::ctrlWordT          ctrl;            // Main decoder output
  logic [2:0]                 aluSelect;
  logic                       subArith;        // Subtract or arithmetic shift
  logic                       csrWrite;
  logic                       fence;           // fence.i or sfence.vma
  logic                       invalidateICache, flushDCache;

  modport mainDec (input clk, input instr, output ctrl);

  modport aluDec (
    input  clk, instr, ctrl,
    output aluSelect, subArith, csrWrite, fence, invalidateICache, flushDCache
  );

  modport pipe (
    input instr, ctrl, aluSelect, subArith, csrWrite, fence, invalidateICache, flushDCache
  );
endinterface

/* hw/mainDecoder.sv */
`timescale 1ns/10ps

module mainDecoder (
  decodeIf.mainDec dec
);
  logic [6:0] op;                              // Opcode
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rs1, rd;
  logic       iShift, iNoShift;                // Shift immediates need funct7 checks
  logic       iFunct, rFunct, mFunct;          // ALU and muldiv encodings
  logic       lFunct, sFunct, bFunct, jrFunct; // Memory and control flow encodings
  logic       fenceFunct, pFunct, csrFunct;    // Fence and system encodings
  ctrlPkg::ctrlWordT cw;

  // Packs one legal control word
  function automatic ctrlPkg::ctrlWordT word(
    input logic       regWrite,
    input logic [2:0] immSrc,
    input logic [1:0] aluSrc,                  // {A, B}
    input logic [1:0] memRw,
    input logic [2:0] resultSrc,
    input logic [3:0] flow,                    // {branch, aluOp, jump, aluResultSrc}
    input logic [3:0] sys                      // {csrRead, privileged, fenceX, mdu}
  );
    word = '{regWrite: regWrite, immSrc: immSrc, aluSrcA: aluSrc[1], aluSrcB: aluSrc[0],
             memRw: memRw, resultSrc: resultSrc, branch: flow[3], aluOp: flow[2],
             jump: flow[1], aluResultSrc: flow[0], csrRead: sys[3], privileged: sys[2],
             fenceX: sys[1], mdu: sys[0], illegal: 1'b0};
  endfunction

  assign op     = dec.instr[6:0];
  assign funct3 = dec.instr[14:12];
  assign funct7 = dec.instr[31:25];
  assign rs1    = dec.instr[19:15];
  assign rd     = dec.instr[11:7];

  //////////////////////////////////////////////////////////////////////
  // Exact field checks

  assign iShift     = (funct3 == 3'b001 & funct7 == ctrlPkg::f7Zero) |
                      (funct3 == 3'b101 & (funct7 == ctrlPkg::f7Zero | funct7 == ctrlPkg::f7Alt));
  assign iNoShift   = (funct3 != 3'b001) & (funct3 != 3'b101);
  assign iFunct     = iShift | iNoShift;
  assign rFunct     = ((funct3 == 3'b000 | funct3 == 3'b101) & funct7 == ctrlPkg::f7Alt) |
                      (funct7 == ctrlPkg::f7Zero); // add/sub, srl/sra and the rest
  assign mFunct     = (funct7 == ctrlPkg::f7MulDiv);
  assign lFunct     = (funct3 != 3'b011) & (funct3 != 3'b110) & (funct3 != 3'b111); // lb..lhu
  assign sFunct     = (funct3 == 3'b000) | (funct3 == 3'b001) | (funct3 == 3'b010);
  assign bFunct     = (funct3[2:1] != 2'b01);   // No branch at 010 or 011
  assign jrFunct    = (funct3 == 3'b000);
  assign fenceFunct = (funct3 == 3'b000) | (funct3 == 3'b001); // fence, fence.i
  assign pFunct     = (funct3 == 3'b000) & (rs1 == 5'b0) & (rd == 5'b0);
  assign csrFunct   = (funct3[1:0] != 2'b00);

  //////////////////////////////////////////////////////////////////////
  // Control word per opcode

  always_comb begin
    cw         = '0;
    cw.illegal = 1'b1;                         // Anything unmatched stays illegal and inert
    case (op)
      ctrlPkg::opLoad:    if (lFunct)          // Loads
        cw = word(1'b1, ctrlPkg::immI, 2'b01, 2'b10, ctrlPkg::resMem, 4'b0000, 4'b0000);
      ctrlPkg::opMiscMem: if (fenceFunct)      // Fences
        cw = word(1'b0, ctrlPkg::immI, 2'b00, 2'b00, ctrlPkg::resAlu, 4'b0000, 4'b0010);
      ctrlPkg::opOpImm:   if (iFunct)          // I-type ALU
        cw = word(1'b1, ctrlPkg::immI, 2'b01, 2'b00, ctrlPkg::resAlu, 4'b0100, 4'b0000);
      ctrlPkg::opAuipc:                        // PC plus upper immediate
        cw = word(1'b1, ctrlPkg::immU, 2'b11, 2'b00, ctrlPkg::resAlu, 4'b0000, 4'b0000);
      ctrlPkg::opStore:   if (sFunct)          // Stores
        cw = word(1'b0, ctrlPkg::immS, 2'b01, 2'b01, ctrlPkg::resAlu, 4'b0000, 4'b0000);
      ctrlPkg::opOp:
        if (rFunct)                            // R-type
          cw = word(1'b1, ctrlPkg::immI, 2'b00, 2'b00, ctrlPkg::resAlu, 4'b0100, 4'b0000);
        else if (mFunct)                       // Multiply and divide
          cw = word(1'b1, ctrlPkg::immI, 2'b00, 2'b00, ctrlPkg::resMdu, 4'b0000, 4'b0001);
      ctrlPkg::opLui:                          // Immediate passes through ALU result mux
        cw = word(1'b1, ctrlPkg::immU, 2'b01, 2'b00, ctrlPkg::resAlu, 4'b0001, 4'b0000);
      ctrlPkg::opBranch:  if (bFunct)          // Target is PC plus offset
        cw = word(1'b0, ctrlPkg::immB, 2'b11, 2'b00, ctrlPkg::resAlu, 4'b1000, 4'b0000);
      ctrlPkg::opJalr:    if (jrFunct)
        cw = word(1'b1, ctrlPkg::immI, 2'b01, 2'b00, ctrlPkg::resAlu, 4'b0011, 4'b0000);
      ctrlPkg::opJal:
        cw = word(1'b1, ctrlPkg::immJ, 2'b11, 2'b00, ctrlPkg::resAlu, 4'b0011, 4'b0000);
      ctrlPkg::opSystem:
        if (pFunct)                            // ecall, mret, sfence.vma and friends
          cw = word(1'b0, ctrlPkg::immI, 2'b00, 2'b00, ctrlPkg::resAlu, 4'b0000, 4'b0100);
        else if (csrFunct)                     // CSR access
          cw = word(1'b1, ctrlPkg::immI, 2'b00, 2'b00, ctrlPkg::resCsr, 4'b0000, 4'b1000);
      default: ;
    endcase
  end

  assign dec.ctrl = cw;

  illegalInert: assert property (@(posedge dec.clk)
    dec.ctrl.illegal |-> !(dec.ctrl.regWrite || (|dec.ctrl.memRw) ||
                           dec.ctrl.branch || dec.ctrl.jump))
    else $error("Illegal instruction carries side effects");

endmodule

/* hw/aluDecoder.sv */
`timescale 1ns/10ps

module aluDecoder (
  decodeIf.aluDec dec
);
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       subOp, sraOp, sltOp, sltuOp;     // Ops that invert or sign the B operand
  logic       csrZeroSrc;                      // rs1 or uimm is zero
  logic       sfenceVma, fenceI;

  assign funct3 = dec.instr[14:12];
  assign funct7 = dec.instr[31:25];

  // Address generation always adds
  assign dec.aluSelect = dec.ctrl.aluOp ? funct3 : 3'b000;

  assign subOp  = (funct3 == 3'b000) & funct7[5] & dec.instr[5]; // instr[5] splits sub from addi
  assign sraOp  = (funct3 == 3'b101) & funct7[5];
  assign sltOp  = (funct3 == 3'b010);
  assign sltuOp = (funct3 == 3'b011);
  assign dec.subArith = dec.ctrl.aluOp & (subOp | sraOp | sltOp | sltuOp);

  //////////////////////////////////////////////////////////////////////
  // CSR and fence actions

  assign csrZeroSrc   = (dec.instr[19:15] == 5'b0);
  assign dec.csrWrite = dec.ctrl.csrRead & ~(csrZeroSrc & funct3[1]); // Set/clear by zero is read only

  assign sfenceVma = dec.ctrl.privileged & (funct7 == 7'b0001001);
  assign fenceI    = dec.ctrl.fenceX & (funct3 == 3'b001);
  assign dec.fence = fenceI | sfenceVma;       // Both flush younger stages from Memory

  // Caches are always present so fence.i acts on both
  assign dec.invalidateICache = fenceI;
  assign dec.flushDCache      = fenceI;

  csrWriteIsCsr: assert property (@(posedge dec.clk) dec.csrWrite |-> dec.ctrl.csrRead)
    else $error("CSR write without CSR read");

endmodule

/* hw/stageReg.sv */
`timescale 1ns/10ps

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    en,                          // Low while the stage stalls
  input  logic    clr,                         // Flush that only lands when enabled
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;
    end else if (en) begin
      q <= clr ? payloadT'('0) : d;            // Stalled stage holds even under flush
    end
  end

  clearedByReset: assert property (@(posedge clk) rst |=> (q == payloadT'('0)))
    else $error("Stage register not cleared by reset");

endmodule

/* hw/executeCtrl.sv */
`timescale 1ns/10ps

module executeCtrl (
  input  ctrlPkg::execCtrlT ctrlE,
  input  logic [1:0]        flagsE,            // {eq, lt}
  input  logic [1:0]        memRwD,
  output logic              pcSrcE,
  output logic              branchSignedE,
  output logic              memReadE,
  output logic              mduActiveE,
  output logic              intDivE,
  output logic              storeStallD,
  output ctrlPkg::memCtrlT  memNext            // Memory stage payload
);
  logic eqE, ltE;
  logic branchFlag, branchTaken;

  //////////////////////////////////////////////////////////////////////
  // Branch resolution

  assign {eqE, ltE}    = flagsE;
  assign branchSignedE = ctrlE.branch & (ctrlE.funct3[2:1] != 2'b11); // bltu and bgeu compare unsigned
  assign branchFlag    = ctrlE.funct3[2] ? ltE : eqE;
  assign branchTaken   = branchFlag ^ ctrlE.funct3[0]; // bne, bge and bgeu invert

  always_comb begin
    pcSrcE = ctrlE.jump | (ctrlE.branch & branchTaken);
    assert (!pcSrcE || ctrlE.jump || ctrlE.branch)
      else $error("PC redirect without jump or branch");
  end

  assign memReadE    = ctrlE.memRw[1];
  assign mduActiveE  = (ctrlE.resultSrc == ctrlPkg::resMdu);
  assign intDivE     = ctrlE.mdu & ctrlE.funct3[2]; // div, divu, rem, remu
  assign storeStallD = ctrlE.memRw[0] & (|memRwD);  // Cache cannot take any access right after a store

  assign memNext = '{regWrite:         ctrlE.regWrite,
                     resultSrc:        ctrlE.resultSrc,
                     memRw:            ctrlE.memRw,
                     csrRead:          ctrlE.csrRead,
                     csrWrite:         ctrlE.csrWrite,
                     privileged:       ctrlE.privileged,
                     funct3:           ctrlE.funct3,
                     invalidateICache: ctrlE.invalidateICache,
                     flushDCache:      ctrlE.flushDCache,
                     fence:            ctrlE.fence,
                     instrValid:       ctrlE.instrValid,
                     intDiv:           intDivE};

endmodule

/* hw/controllerTop.sv */
`timescale 1ns/10ps

module controllerTop (
  input  logic                       clk,
  input  logic                       rst,
  // Decode
  input  logic                       stallD, flushD,
  input  logic [ctrlPkg::instrW-1:0] instrD,
  output logic [2:0]                 immSrcD,
  output logic                       illegalBaseInstrD,
  output logic                       jumpD, branchD,
  output logic                       storeStallD,
  output logic                       instrValidD,
  // Execute
  input  logic                       stallE, flushE,
  input  logic [1:0]                 flagsE,   // {eq, lt}
  output logic                       pcSrcE,
  output logic                       aluSrcAE, aluSrcBE,
  output logic                       aluResultSrcE,
  output logic [2:0]                 aluSelectE,
  output logic                       memReadE, csrReadE,
  output logic [2:0]                 funct3E,
  output logic                       intDivE, mduE, subArithE,
  output logic                       jumpE, branchE, branchSignedE,
  output logic                       mduActiveE, instrValidE,
  // Memory
  input  logic                       stallM, flushM,
  output logic [1:0]                 memRwM,   // Bit 1 read, bit 0 write
  output logic                       csrReadM, csrWriteM, privilegedM,
  output logic [2:0]                 funct3M,
  output logic                       regWriteM,
  output logic                       invalidateICacheM, flushDCacheM,
  output logic                       instrValidM,
  output logic                       csrWriteFenceM, // Flushes younger stages
  // Writeback
  input  logic                       stallW, flushW,
  output logic                       regWriteW, intDivW,
  output logic [2:0]                 resultSrcW
);
  ctrlPkg::execCtrlT execD, execE;
  ctrlPkg::memCtrlT  memE, memM;
  ctrlPkg::wbCtrlT   wbM, wbW;

  //////////////////////////////////////////////////////////////////////
  // Decode

  decodeIf    dec (.clk);
  mainDecoder mainDec (.dec(dec.mainDec));
  aluDecoder  aluDec (.dec(dec.aluDec));

  assign dec.instr         = instrD;
  assign immSrcD           = dec.ctrl.immSrc;
  assign illegalBaseInstrD = dec.ctrl.illegal;
  assign jumpD             = dec.ctrl.jump;
  assign branchD           = dec.ctrl.branch;

  stageReg #(.payloadT(logic)) regD (
    .clk, .rst, .en(~stallD), .clr(flushD), .d(1'b1), .q(instrValidD)
  );

  assign execD = '{aluSelect: dec.aluSelect, regWrite: dec.ctrl.regWrite,
                   resultSrc: dec.ctrl.resultSrc, memRw: dec.ctrl.memRw,
                   jump: dec.ctrl.jump, branch: dec.ctrl.branch,
                   aluSrcA: dec.ctrl.aluSrcA, aluSrcB: dec.ctrl.aluSrcB,
                   aluResultSrc: dec.ctrl.aluResultSrc, csrRead: dec.ctrl.csrRead,
                   csrWrite: dec.csrWrite, privileged: dec.ctrl.privileged,
                   funct3: instrD[14:12], subArith: dec.subArith, mdu: dec.ctrl.mdu,
                   invalidateICache: dec.invalidateICache, flushDCache: dec.flushDCache,
                   fence: dec.fence, instrValid: instrValidD};

  //////////////////////////////////////////////////////////////////////
  // Execute

  stageReg #(.payloadT(ctrlPkg::execCtrlT)) regE (
    .clk, .rst, .en(~stallE), .clr(flushE), .d(execD), .q(execE)
  );

  executeCtrl exec (
    .ctrlE(execE), .flagsE, .memRwD(dec.ctrl.memRw), .pcSrcE, .branchSignedE,
    .memReadE, .mduActiveE, .intDivE, .storeStallD, .memNext(memE)
  );

  assign aluSrcAE      = execE.aluSrcA;
  assign aluSrcBE      = execE.aluSrcB;
  assign aluResultSrcE = execE.aluResultSrc;
  assign aluSelectE    = execE.aluSelect;
  assign csrReadE      = execE.csrRead;
  assign funct3E       = execE.funct3;
  assign mduE          = execE.mdu;
  assign subArithE     = execE.subArith;
  assign jumpE         = execE.jump;
  assign branchE       = execE.branch;
  assign instrValidE   = execE.instrValid;

  //////////////////////////////////////////////////////////////////////
  // Memory and Writeback

  stageReg #(.payloadT(ctrlPkg::memCtrlT)) regM (
    .clk, .rst, .en(~stallM), .clr(flushM), .d(memE), .q(memM)
  );

  assign memRwM            = memM.memRw;
  assign csrReadM          = memM.csrRead;
  assign csrWriteM         = memM.csrWrite;
  assign privilegedM       = memM.privileged;
  assign funct3M           = memM.funct3;
  assign regWriteM         = memM.regWrite;
  assign invalidateICacheM = memM.invalidateICache;
  assign flushDCacheM      = memM.flushDCache;
  assign instrValidM       = memM.instrValid;
  assign csrWriteFenceM    = memM.csrWrite | memM.fence;

  assign wbM = '{regWrite: memM.regWrite, resultSrc: memM.resultSrc, intDiv: memM.intDiv};

  stageReg #(.payloadT(ctrlPkg::wbCtrlT)) regW (
    .clk, .rst, .en(~stallW), .clr(flushW), .d(wbM), .q(wbW)
  );

  assign regWriteW  = wbW.regWrite;
  assign intDivW    = wbW.intDiv;
  assign resultSrcW = wbW.resultSrc;

endmodule

/* include/controllerRef.svh */
`ifndef CONTROLLER_REF_SVH
`define CONTROLLER_REF_SVH

typedef struct packed {
  logic              illegal;
  logic [2:0]        immSrc;
  ctrlPkg::execCtrlT ex;                       // Expected Execute payload with instrValid low
} refDecT;

logic              refValidD;                  // Model copies of the four stage registers
ctrlPkg::execCtrlT refE;
ctrlPkg::memCtrlT  refM;
ctrlPkg::wbCtrlT   refW;

// Row {legal, wr, imm, srcA, srcB, rd, wr, res, aluOp, jump, branch, aluRes, csr, priv, mdu}
function automatic refDecT refDecode(input logic [31:0] instr);
  logic [6:0]  op, f7;
  logic [2:0]  f3;
  logic        rs1Zero, rdZero, fenceI, sfence, sub, csrWr;
  logic [18:0] row;
  refDecT      r;
  op      = instr[6:0];
  f3      = instr[14:12];
  f7      = instr[31:25];
  rs1Zero = (instr[19:15] == 5'd0);
  rdZero  = (instr[11:7] == 5'd0);
  row     = '0;                                // Unmatched stays illegal with no control
  case (op)
    ctrlPkg::opLoad:    if (!(f3 inside {3'd3, 3'd6, 3'd7}))
      row = {2'b11, ctrlPkg::immI, 2'b01, 2'b10, ctrlPkg::resMem, 7'b0000000};
    ctrlPkg::opMiscMem: if (f3 inside {3'd0, 3'd1})
      row = {2'b10, ctrlPkg::immI, 2'b00, 2'b00, ctrlPkg::resAlu, 7'b0000000};
    ctrlPkg::opOpImm:   if (!((f3 == 3'd1 && f7 != 7'd0) ||
                              (f3 == 3'd5 && f7 != 7'd0 && f7 != 7'h20)))
      row = {2'b11, ctrlPkg::immI, 2'b01, 2'b00, ctrlPkg::resAlu, 7'b1000000};
    ctrlPkg::opAuipc:
      row = {2'b11, ctrlPkg::immU, 2'b11, 2'b00, ctrlPkg::resAlu, 7'b0000000};
    ctrlPkg::opStore:   if (f3 <= 3'd2)
      row = {2'b10, ctrlPkg::immS, 2'b01, 2'b01, ctrlPkg::resAlu, 7'b0000000};
    ctrlPkg::opOp:
      if (f7 == ctrlPkg::f7Zero || (f7 == ctrlPkg::f7Alt && f3 inside {3'd0, 3'd5}))
        row = {2'b11, ctrlPkg::immI, 2'b00, 2'b00, ctrlPkg::resAlu, 7'b1000000};
      else if (f7 == ctrlPkg::f7MulDiv)
        row = {2'b11, ctrlPkg::immI, 2'b00, 2'b00, ctrlPkg::resMdu, 7'b0000001};
    ctrlPkg::opLui:
      row = {2'b11, ctrlPkg::immU, 2'b01, 2'b00, ctrlPkg::resAlu, 7'b0001000};
    ctrlPkg::opBranch:  if (!(f3 inside {3'd2, 3'd3}))
      row = {2'b10, ctrlPkg::immB, 2'b11, 2'b00, ctrlPkg::resAlu, 7'b0010000};
    ctrlPkg::opJalr:    if (f3 == 3'd0)
      row = {2'b11, ctrlPkg::immI, 2'b01, 2'b00, ctrlPkg::resAlu, 7'b0101000};
    ctrlPkg::opJal:
      row = {2'b11, ctrlPkg::immJ, 2'b11, 2'b00, ctrlPkg::resAlu, 7'b0101000};
    ctrlPkg::opSystem:
      if (f3 == 3'd0 && rs1Zero && rdZero)     // Privileged forms
        row = {2'b10, ctrlPkg::immI, 2'b00, 2'b00, ctrlPkg::resAlu, 7'b0000010};
      else if (!(f3 inside {3'd0, 3'd4}))      // CSR access
        row = {2'b11, ctrlPkg::immI, 2'b00, 2'b00, ctrlPkg::resCsr, 7'b0000100};
    default: ;
  endcase
  fenceI = row[18] && (op == ctrlPkg::opMiscMem) && (f3 == 3'd1);
  sfence = row[1] && (f7 == 7'b0001001);
  sub    = row[6] && ((f3 inside {3'd2, 3'd3}) || (f7 == ctrlPkg::f7Alt &&
           (f3 == 3'd5 || (f3 == 3'd0 && op == ctrlPkg::opOp))));
  csrWr  = row[2] && !(rs1Zero && (f3 inside {3'd2, 3'd3, 3'd6, 3'd7})); // Set/clear by zero
  r.illegal = !row[18];
  r.immSrc  = row[16:14];
  r.ex = '{aluSelect: row[6] ? f3 : 3'b000, regWrite: row[17], resultSrc: row[9:7],
           memRw: row[11:10], jump: row[5], branch: row[4], aluSrcA: row[13],
           aluSrcB: row[12], aluResultSrc: row[3], csrRead: row[2], csrWrite: csrWr,
           privileged: row[1], funct3: f3, subArith: sub, mdu: row[0],
           invalidateICache: fenceI, flushDCache: fenceI, fence: fenceI | sfence,
           instrValid: 1'b0};
  return r;
endfunction

function automatic ctrlPkg::memCtrlT toMem(input ctrlPkg::execCtrlT e);
  return '{regWrite: e.regWrite, resultSrc: e.resultSrc, memRw: e.memRw, csrRead: e.csrRead,
           csrWrite: e.csrWrite, privileged: e.privileged, funct3: e.funct3,
           invalidateICache: e.invalidateICache, flushDCache: e.flushDCache, fence: e.fence,
           instrValid: e.instrValid, intDiv: e.mdu && (e.funct3 >= 3'd4)}; // Divides and rems
endfunction

// Stall and flush are {D, E, M, W}
task automatic stepModel(input logic rstIn, input logic [31:0] instr,
                         input logic [3:0] stall, input logic [3:0] flush);
  refDecT            t;
  ctrlPkg::execCtrlT dNext;
  t = refDecode(instr);
  dNext = t.ex;
  dNext.instrValid = refValidD;
  if (rstIn) begin
    refValidD <= 1'b0;
    refE      <= '0;
    refM      <= '0;
    refW      <= '0;
  end else begin                               // Stalled stage holds even under flush
    if (!stall[3]) refValidD <= !flush[3];
    if (!stall[2]) refE <= flush[2] ? ctrlPkg::execCtrlT'('0) : dNext;
    if (!stall[1]) refM <= flush[1] ? ctrlPkg::memCtrlT'('0) : toMem(refE);
    if (!stall[0]) refW <= flush[0] ? ctrlPkg::wbCtrlT'('0) :
                                      '{refM.regWrite, refM.resultSrc, refM.intDiv};
  end
endtask

`endif

/* testbench/controllerTb.sv */
`timescale 1ns/10ps

module controllerTb;
  logic        clk, rst;
  logic        stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW;
  logic [31:0] instrD;
  logic [1:0]  flagsE;                         // {eq, lt}
  logic [2:0]  immSrcD, aluSelectE, funct3E, funct3M, resultSrcW;
  logic        illegalBaseInstrD, jumpD, branchD, storeStallD, instrValidD;
  logic        pcSrcE, aluSrcAE, aluSrcBE, aluResultSrcE, memReadE, csrReadE, intDivE, mduE;
  logic        subArithE, jumpE, branchE, branchSignedE, mduActiveE, instrValidE;
  logic [1:0]  memRwM;
  logic        csrReadM, csrWriteM, privilegedM, regWriteM, invalidateICacheM, flushDCacheM;
  logic        instrValidM, csrWriteFenceM, regWriteW, intDivW;
  integer      seed = 32'h2d4b;
  int          errCount = 0;
  int          checkCount = 0;
  int          testCount = 0;
  logic        done = 1'b0;
  logic [6:0]  opTable [18] = '{ctrlPkg::opLoad, ctrlPkg::opMiscMem, ctrlPkg::opOpImm,
    ctrlPkg::opAuipc, ctrlPkg::opStore, ctrlPkg::opOp, ctrlPkg::opOp, ctrlPkg::opLui,
    ctrlPkg::opBranch, ctrlPkg::opJalr, ctrlPkg::opJal, ctrlPkg::opSystem, ctrlPkg::opSystem,
    ctrlPkg::opSystem, 7'h7f, ctrlPkg::opLoad, ctrlPkg::opOp, 7'h00}; // Kinds 13 up are bad

  `include "controllerRef.svh"

  controllerTop controllerTop_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) stepModel(rst, instrD, {stallD, stallE, stallM, stallW},
                                  {flushD, flushE, flushM, flushW});

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  function automatic logic [31:0] makeInstr(input int kind);
    logic [31:0] r;
    logic [6:0]  f7, op;
    logic [4:0]  rs2, rs1, rd;
    logic [2:0]  f3;
    r = $random(seed);
    {f7, rs2, rs1, f3, rd} = r[31:7];          // Random fields forced legal per kind
    op = (kind == 17) ? r[6:0] : opTable[kind];
    case (kind)
      0:  f3 = (f3 inside {3'd3, 3'd6, 3'd7}) ? 3'b100 : f3; // Load widths
      1:  f3 = {2'b00, f3[0]};                 // fence or fence.i
      2:  f7 = (f3 == 3'd1) ? 7'd0 : (f3 == 3'd5) ? {1'b0, f7[5], 5'd0} : f7;
      4:  f3 = {1'b0, f3[1], f3[0] & ~f3[1]};  // sb, sh, sw
      5:  f7 = (f3 inside {3'd0, 3'd5}) ? {1'b0, f7[5], 5'd0} : 7'd0;
      6:  f7 = ctrlPkg::f7MulDiv;
      8:  f3 = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
      9:  f3 = 3'd0;
      11: begin                                // CSR access with a zero source half the time
        f3  = (f3[1:0] == 2'b00) ? {f3[2], 2'b10} : f3;
        rs1 = r[0] ? 5'd0 : rs1;
      end
      12: begin                                // ecall family or sfence.vma
        f7  = r[1] ? 7'b0001001 : f7;
        rs1 = 5'd0;
        f3  = 3'd0;
        rd  = 5'd0;
      end
      13: begin                                // Privileged with non-zero rd
        f3 = 3'd0;
        rd = rd | 5'd1;
      end
      15: f3 = 3'b110;                         // No such load
      16: f7 = 7'h7f;
      default: ;
    endcase
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  task automatic checkField(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    assert (got === exp)
      else begin
        $display("ERR %0t: %s mismatch, got %h expected %h", $time, name, got, exp);
        errCount++;
      end
  endtask

  function automatic logic takenRef(input ctrlPkg::execCtrlT e, input logic [1:0] flags);
    logic cond;
    cond = e.funct3[2] ? flags[0] : flags[1];  // lt family or eq family
    return e.jump || (e.branch && (cond != e.funct3[0]));
  endfunction

  // Mode 0 legal sweep, 1 illegal, 2 control flow, 3 random, 4 CSR/fence, 5 store, 6 stalls
  task automatic runTest(input string name, input int mode, input int count);
    int          errBefore;
    int          kind;
    int          sweep;
    logic [31:0] rnd;
    errBefore = errCount;
    for (int i = 0; i < count + 4; i++) begin  // Four nops drain the pipeline
      @(negedge clk);
      rnd = $random(seed);
      case (mode)
        0:       kind = i % 13;
        1:       kind = 13 + i % 5;
        2:       kind = 8 + i % 3;
        3, 6:    kind = $unsigned($random(seed)) % 18;
        4:       kind = (i % 2 == 0) ? 11 : 1;
        default: kind = (i % 2 == 0) ? 4 : (rnd[1] ? 2 : (rnd[0] ? 0 : 4));
      endcase
      instrD = (i < count) ? makeInstr(kind) : 32'h0000_0013;
      flagsE = rnd[31:30];
      if (mode == 2 && i < count) begin        // Each branch funct3 meets each flag pair
        sweep  = (i / 3) % 6;
        flagsE = 2'((i / 18) % 4);
        if (kind == 8) instrD[14:12] = (sweep < 2) ? 3'(sweep) : 3'(sweep + 2);
      end
      if (mode == 6 && i < count) begin        // About one in eight per stage
        {stallD, stallE, stallM, stallW} = rnd[3:0] & rnd[7:4] & rnd[11:8];
        {flushD, flushE, flushM, flushW} = rnd[15:12] & rnd[19:16] & rnd[23:20];
      end else begin
        {stallD, stallE, stallM, stallW} = 4'b0000;
        {flushD, flushE, flushM, flushW} = 4'b0000;
      end
    end
    @(posedge clk);                            // Last vector compared before the report
    testCount++;
    $display("Test %s: %0d errors", name, errCount - errBefore);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare and run

  initial begin : compare
    refDecT           dRef;
    ctrlPkg::memCtrlT mRef;
    forever begin
      @(negedge clk);
      #10;                                     // New Decode word applied, registers settled
      dRef = refDecode(instrD);
      mRef = toMem(refE);
      checkField("decode", 64'({immSrcD, illegalBaseInstrD, jumpD, branchD, instrValidD}),
                 64'({dRef.immSrc, dRef.illegal, dRef.ex.jump, dRef.ex.branch, refValidD}));
      checkField("store stall", 64'(storeStallD), 64'(refE.memRw[0] && (|dRef.ex.memRw)));
      checkField("branch", 64'({pcSrcE, branchSignedE}), 64'({takenRef(refE, flagsE),
                 refE.branch && !(refE.funct3 inside {3'd6, 3'd7})}));
      checkField("execute", 64'({aluSrcAE, aluSrcBE, aluResultSrcE, aluSelectE, memReadE,
                 csrReadE, funct3E, intDivE, mduE, subArithE, jumpE, branchE, mduActiveE,
                 instrValidE}), 64'({refE.aluSrcA, refE.aluSrcB, refE.aluResultSrc,
                 refE.aluSelect, refE.memRw[1], refE.csrRead, refE.funct3, mRef.intDiv,
                 refE.mdu, refE.subArith, refE.jump, refE.branch, refE.mdu,
                 refE.instrValid}));
      checkField("memory", 64'({memRwM, csrReadM, csrWriteM, privilegedM, funct3M, regWriteM,
                 invalidateICacheM, flushDCacheM, instrValidM, csrWriteFenceM}),
                 64'({refM.memRw, refM.csrRead, refM.csrWrite, refM.privileged, refM.funct3,
                 refM.regWrite, refM.invalidateICache, refM.flushDCache, refM.instrValid,
                 refM.csrWrite | refM.fence}));
      checkField("writeback", 64'({regWriteW, intDivW, resultSrcW}),
                 64'({refW.regWrite, refW.intDiv, refW.resultSrc}));
    end
  end

  initial begin : watchdog
    for (int i = 0; i < 2000 && !done; i++) @(posedge clk);
    if (!done) begin
      $display("Timeout: stimulus did not finish within 2000 clock cycles");
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin : stimulus
    rst    = 1'b1;
    instrD = 32'h0000_0013;                    // addi x0, x0, 0
    flagsE = 2'b00;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = 8'h00;
    for (int i = 0; i < 5; i++) @(negedge clk);
    rst = 1'b0;
    runTest("decode", 0, 65);
    runTest("illegal encodings", 1, 40);
    runTest("branch resolution", 2, 72);
    runTest("pipeline progression", 3, 100);
    runTest("pipeline stall and flush", 6, 200);
    runTest("csr and fence", 4, 60);
    runTest("store stall", 5, 60);
    done = 1'b1;
    $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
    if (errCount == 0) $display("SIMULATION PASSED");
    else $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* build.f */
+incdir+include
hw/ctrlPkg.sv
hw/decodeIf.sv
hw/mainDecoder.sv
hw/aluDecoder.sv
hw/stageReg.sv
hw/executeCtrl.sv
hw/controllerTop.sv
testbench/controllerTb.sv

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module controllerTb -f build.f -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VcontrollerTb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
